// ==== verification/te_stim.txt ====
// test enable len first step rounds block_sum, all hex, test 0 ends the list
// sample k = first + k*step mod 256, signed; block_sum is sign-extended to 32 bits
01 00000000 04 01 01 00 00000000
02 00000001 04 01 01 01 0000000a
03 0000000f 08 10 10 01 00000140
04 0000001f 05 fe ff 02 ffffffec
05 80000001 03 7f 00 01 0000017d
06 ffffffff 0a 00 03 08 00000087
07 00ff00ff 06 80 01 04 fffffd0f
08 12345678 07 40 40 04 ffffff00
09 a5a5a5a5 02 7f 7f 04 0000007d
0a 00000100 10 f0 01 01 ffffff78
00 00000000 00 00 00 00 00000000

// ==== sources.f ====
rtl/te_pkg.sv
rtl/te_sequencer.sv
rtl/settle_timer.sv
rtl/channel_finder.sv
rtl/sample_integrator.sv
rtl/te_host_regs.sv
rtl/tracking_engine.sv
verification/tb_tracking_engine.sv

// ==== verification/tb_tracking_engine.sv ====
//--------------------------------------------------
// testbench, one test per line of te_stim.txt
// tests run back to back with no reset between them
//--------------------------------------------------
module tb_tracking_engine
	import te_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_TESTS = 32;
	localparam int COLS      = 7;	// words per stimulus line

	logic               clk;
	logic               rst_b;
	logic               te_start;
	host_bus_t          host;
	fifo_in_t           fifo;
	logic               fifo_read;
	logic               fifo_rewind;
	logic               fifo_skip;
	logic               te_running;
	logic               te_ready;
	logic               te_over;
	logic [HOST_DW-1:0] reg_rdata;

	logic [31:0] stim [MAX_TESTS*COLS];
	integer      seed;
	int          errors;
	int          test_num;
	int          num_tests;
	int          limit_cycles;
	int          n_read;
	int          n_rewind;
	int          n_skip;
	int          n_over;
	int          blk_len;	// current fifo block
	logic [7:0]  blk_first;
	logic [7:0]  blk_step;

	tracking_engine DUT (
		.clk           (clk        ),
		.rst_b         (rst_b      ),
		.i_te_start    (te_start   ),
		.i_host        (host       ),
		.i_fifo        (fifo       ),
		.o_fifo_read   (fifo_read  ),
		.o_fifo_rewind (fifo_rewind),
		.o_fifo_skip   (fifo_skip  ),
		.o_te_running  (te_running ),
		.o_te_ready    (te_ready   ),
		.o_te_over     (te_over    ),
		.o_reg_rdata   (reg_rdata  )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// strobe counters, one count per high cycle
	always @(posedge clk) begin
		if (rst_b) begin
			n_read   = n_read + int'(fifo_read);
			n_rewind = n_rewind + int'(fifo_rewind);
			n_skip   = n_skip + int'(fifo_skip);
			n_over   = n_over + int'(te_over);
		end
	end

	//--------------------------------------------------
	// fifo model, streams the block after each read
	//--------------------------------------------------
	always begin
		@(negedge clk);
		if (fifo_read) begin
			for (int k = 0; k < blk_len; k++) begin
				@(negedge clk);	// state is CORRELATION from here
				fifo.data       = 8'(blk_first + k * blk_step);
				fifo.data_valid = 1'b1;
				fifo.last_data  = (k == blk_len - 1);
			end
			@(negedge clk);
			fifo.data_valid = 1'b0;
			fifo.last_data  = 1'b0;
		end
	end

	task automatic host_write(input logic [HOST_AW-1:0] addr, input logic [HOST_DW-1:0] data);
		@(negedge clk);
		host.reg_cs = 1'b1;
		host.wr     = 1'b1;
		host.addr   = addr;
		host.wdata  = data;
		@(negedge clk);
		host.reg_cs = 1'b0;
		host.wr     = 1'b0;
	endtask

	task automatic host_read(input logic [HOST_AW-1:0] addr, output logic [HOST_DW-1:0] data);
		@(negedge clk);
		host.reg_cs = 1'b1;
		host.rd     = 1'b1;
		host.addr   = addr;
		@(posedge clk);
		data = reg_rdata;
		@(negedge clk);
		host.reg_cs = 1'b0;
		host.rd     = 1'b0;
	endtask

	task automatic check_reg(input string what, input logic [HOST_DW-1:0] exp,
		input logic [HOST_DW-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERR test %0d %s: expected %h, actual %h", test_num, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("ERR test %0d %s: expected %0d, actual %0d", test_num, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR test %0d %s: expected %b, actual %b", test_num, what, exp, act);
		end
	endtask

	//--------------------------------------------------
	// one test: program, start, wait for te_over, check
	//--------------------------------------------------
	task automatic run_test(input int t);
		logic [HOST_DW-1:0] rd;
		logic [31:0]        mask;
		int                 rounds;
		int                 gap;
		test_num  = int'(stim[t*COLS]);
		mask      = stim[t*COLS+1];
		blk_len   = int'(stim[t*COLS+2]);
		blk_first = stim[t*COLS+3][7:0];
		blk_step  = stim[t*COLS+4][7:0];
		rounds    = int'(stim[t*COLS+5]);
		host_write(REG_CHANNEL_ENABLE, mask);
		host_read(REG_CHANNEL_ENABLE, rd);
		check_reg("enable readback", mask, rd);
		host_read(6'h3f, rd);
		check_reg("unmapped read", '0, rd);
		gap = 1 + int'($unsigned($random(seed)) % 6);
		repeat (gap) @(negedge clk);
		check_bit("running before start", 1'b0, te_running);
		n_read   = 0;
		n_rewind = 0;
		n_skip   = 0;
		n_over   = 0;
		te_start   = 1'b1;
		fifo.ready = 1'b1;
		@(negedge clk);
		te_start = 1'b0;
		check_bit("running after start", 1'b1, te_running);
		while (te_over !== 1'b1) @(negedge clk);	// watchdog ends a hang
		fifo.ready = 1'b0;
		@(negedge clk);
		check_count("fifo reads", rounds, n_read);
		check_count("fifo rewinds", (rounds > 0) ? rounds - 1 : 0, n_rewind);
		check_count("fifo skips", 1, n_skip);
		check_count("te_over pulses", 1, n_over);
		check_bit("running after over", 1'b0, te_running);
		check_bit("te_ready", (mask != 0), te_ready);
		host_read(REG_COH_DATA_READY, rd);
		check_reg("coh data ready", mask, rd);
		host_read(REG_BLOCK_SUM, rd);
		check_reg("block sum", stim[t*COLS+6], rd);
		host_read(REG_CURR_STATE, rd);
		check_reg("state readback", HOST_DW'(WAIT_CPU), rd);
		check_bit("running in wait", 1'b0, te_running);
	endtask

	initial begin
		rst_b        = 1'b0;
		te_start     = 1'b0;
		host         = '0;
		fifo         = '0;
		errors       = 0;
		test_num     = 0;
		num_tests    = 0;
		blk_len      = 0;
		blk_first    = '0;
		blk_step     = '0;
		n_read       = 0;
		n_rewind     = 0;
		n_skip       = 0;
		n_over       = 0;
		seed         = 32'hfe4e;
		for (int i = 0; i < MAX_TESTS * COLS; i++) begin
			stim[i] = '0;
		end
		$readmemh("verification/te_stim.txt", stim);
		// test number zero ends the list
		while ((num_tests < MAX_TESTS) && (stim[num_tests*COLS] != 0)) begin
			limit_cycles += 200 * int'(stim[num_tests*COLS+2]);
			num_tests++;
		end
		limit_cycles += 500;	// reset and host accesses
		if (num_tests == 0) begin
			errors++;
			$display("no tests could be read from verification/te_stim.txt");
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_b = 1'b1;
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		$display("tests run %0d, errors %0d", num_tests, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (limit_cycles > 500);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: tests still running after %0d cycles, the engine seems hung",
			limit_cycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== rtl/tracking_engine.sv ====
//--------------------------------------------------
// tracking engine round scheduler, top level
// fifo must hold a full block once ready is high
//--------------------------------------------------
module tracking_engine
	import te_pkg::*;
#(
	parameter int COR_SETTLE = 5	// cycles from last sample to dump
) (
	input  logic               clk,
	input  logic               rst_b,
	input  logic               i_te_start,
	input  host_bus_t          i_host,
	input  fifo_in_t           i_fifo,
	output logic               o_fifo_read,
	output logic               o_fifo_rewind,
	output logic               o_fifo_skip,
	output logic               o_te_running,
	output logic               o_te_ready,
	output logic               o_te_over,
	output logic [HOST_DW-1:0] o_reg_rdata
);

	te_state_t               state;
	logic                    enable_any;
	logic                    find_done;
	logic                    cor_done;
	logic                    channels_left;
	slot_map_t               slot_map;
	logic [NUM_CHANNELS-1:0] enable;
	logic signed [15:0]      block_sum;

	te_sequencer u_sequencer (
		.clk             (clk          ),
		.rst_b           (rst_b        ),
		.i_te_start      (i_te_start   ),
		.i_fifo_ready    (i_fifo.ready ),
		.i_enable_any    (enable_any   ),
		.i_find_done     (find_done    ),
		.i_cor_done      (cor_done     ),
		.i_channels_left (channels_left),
		.o_state         (state        ),
		.o_fifo_read     (o_fifo_read  ),
		.o_fifo_rewind   (o_fifo_rewind),
		.o_fifo_skip     (o_fifo_skip  ),
		.o_te_running    (o_te_running ),
		.o_te_over       (o_te_over    )
	);

	settle_timer #(.COR_SETTLE(COR_SETTLE)) u_settle_timer (
		.clk         (clk             ),
		.rst_b       (rst_b           ),
		.i_last_data (i_fifo.last_data),
		.i_state     (state           ),
		.o_cor_done  (cor_done        )
	);

	channel_finder u_channel_finder (
		.clk             (clk          ),
		.rst_b           (rst_b        ),
		.i_state         (state        ),
		.i_enable        (enable       ),
		.o_enable_any    (enable_any   ),
		.o_find_done     (find_done    ),
		.o_slot_map      (slot_map     ),
		.o_channels_left (channels_left)
	);

	sample_integrator u_sample_integrator (
		.clk         (clk      ),
		.rst_b       (rst_b    ),
		.i_state     (state    ),
		.i_fifo      (i_fifo   ),
		.o_block_sum (block_sum)
	);

	te_host_regs u_host_regs (
		.clk         (clk        ),
		.rst_b       (rst_b      ),
		.i_host      (i_host     ),
		.i_state     (state      ),
		.i_slot_map  (slot_map   ),
		.i_block_sum (block_sum  ),
		.o_enable    (enable     ),
		.o_te_ready  (o_te_ready ),
		.o_reg_rdata (o_reg_rdata)
	);

endmodule

// ==== rtl/te_host_regs.sv ====
//--------------------------------------------------
// host registers with combinational read data
// a host write beats the engine update
//--------------------------------------------------
module te_host_regs
	import te_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_b,
	input  host_bus_t               i_host,
	input  te_state_t               i_state,
	input  slot_map_t               i_slot_map,
	input  logic signed [15:0]      i_block_sum,
	output logic [NUM_CHANNELS-1:0] o_enable,
	output logic                    o_te_ready,
	output logic [HOST_DW-1:0]      o_reg_rdata
);

	logic                    host_wr;
	logic [NUM_CHANNELS-1:0] channel_enable;
	logic [NUM_CHANNELS-1:0] coh_data_ready;

	assign host_wr = i_host.reg_cs && i_host.wr;

	//--------------------------------------------------
	// writes
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			channel_enable <= '0;
		end else if (host_wr && (i_host.addr == REG_CHANNEL_ENABLE)) begin
			channel_enable <= i_host.wdata[NUM_CHANNELS-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			coh_data_ready <= '0;
		end else if (host_wr && (i_host.addr == REG_COH_DATA_READY)) begin
			coh_data_ready <= i_host.wdata[NUM_CHANNELS-1:0];
		end else if (i_state == DUMP_STATE) begin
			coh_data_ready <= coh_data_ready | i_slot_map.mask;	// round finished
		end else if (i_state == START) begin
			coh_data_ready <= '0;
		end
	end

	assign o_enable   = channel_enable;
	assign o_te_ready = |coh_data_ready;

	//--------------------------------------------------
	// reads
	//--------------------------------------------------
	always_comb begin
		o_reg_rdata = '0;
		if (i_host.reg_cs && i_host.rd) begin
			case (i_host.addr)
				REG_CHANNEL_ENABLE : o_reg_rdata = HOST_DW'(channel_enable);
				REG_COH_DATA_READY : o_reg_rdata = HOST_DW'(coh_data_ready);
				REG_BLOCK_SUM      : o_reg_rdata = {{(HOST_DW - 16){i_block_sum[15]}}, i_block_sum};
				REG_CURR_STATE     : o_reg_rdata = HOST_DW'(i_state);
				default            : o_reg_rdata = '0;	// unmapped
			endcase
		end
	end

endmodule

// ==== rtl/sample_integrator.sv ====
//--------------------------------------------------
// raw integrate and dump of one fifo block
// no wipe-off; sum wraps past 16 bits
//--------------------------------------------------
module sample_integrator
	import te_pkg::*;
(
	input  logic               clk,
	input  logic               rst_b,
	input  te_state_t          i_state,
	input  fifo_in_t           i_fifo,
	output logic signed [15:0] o_block_sum
);

	logic signed [15:0] acc;
	logic signed [15:0] sample_ext;

	assign sample_ext = {{(16 - SAMPLE_W){i_fifo.data[SAMPLE_W-1]}}, i_fifo.data};

	// accumulator
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			acc <= '0;
		end else if (i_state == READ_FIFO) begin
			acc <= '0;	// fresh sum for each round
		end else if ((i_state == CORRELATION) && i_fifo.data_valid) begin
			acc <= acc + sample_ext;
		end
	end

	// dump
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_block_sum <= '0;
		end else if (i_state == DUMP_STATE) begin
			o_block_sum <= acc;	// held until the next dump
		end
	end

endmodule

// ==== rtl/channel_finder.sv ====
//--------------------------------------------------
// assigns up to NUM_SLOTS pending channels per round
// lowest channel first, one channel per cycle
//--------------------------------------------------
module channel_finder
	import te_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_b,
	input  te_state_t               i_state,
	input  logic [NUM_CHANNELS-1:0] i_enable,
	output logic                    o_enable_any,
	output logic                    o_find_done,
	output slot_map_t               o_slot_map,
	output logic                    o_channels_left
);

	localparam int SLOT_W = $clog2(NUM_SLOTS);

	logic [NUM_CHANNELS-1:0] remaining;	// channels not yet served in this block
	logic [NUM_CHANNELS-1:0] lowest;
	logic [NUM_CHANNELS-1:0] rest;
	logic [SLOT_W-1:0]       taken;
	slot_map_t               slot_map;

	assign lowest = remaining & (~remaining + NUM_CHANNELS'(1));	// isolate lowest set bit
	assign rest   = remaining & ~lowest;

	// remaining channels
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			remaining <= '0;
		end else if (i_state == IDLE) begin
			remaining <= i_enable;	// last idle cycle gives the mask at START
		end else if (i_state == FIND_CHANNEL) begin
			remaining <= rest;
		end
	end

	// slot map of the current round
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			slot_map <= '0;
			taken    <= '0;
		end else if ((i_state == START) || (i_state == COR_FINISH)) begin
			slot_map <= '0;	// next state may be FIND_CHANNEL
			taken    <= '0;
		end else if (i_state == FIND_CHANNEL) begin
			slot_map.mask <= slot_map.mask | lowest;
			taken         <= taken + 1'b1;
		end
	end

	// done in the cycle that takes the last channel of the round
	assign o_find_done = (i_state == FIND_CHANNEL) &&
		((taken == SLOT_W'(NUM_SLOTS - 1)) || (rest == '0));

	assign o_enable_any    = |remaining;
	assign o_channels_left = |remaining;
	assign o_slot_map      = slot_map;

	a_slot_limit: assert property (@(posedge clk) disable iff (!rst_b)
		$countones(o_slot_map.mask) <= NUM_SLOTS);

endmodule

// ==== rtl/settle_timer.sv ====
//--------------------------------------------------
// correlator settle delay after the last sample
// COR_SETTLE must be at least 1
//--------------------------------------------------
module settle_timer
	import te_pkg::*;
#(
	parameter int COR_SETTLE = 5
) (
	input  logic      clk,
	input  logic      rst_b,
	input  logic      i_last_data,
	input  te_state_t i_state,
	output logic      o_cor_done
);

	localparam int CNT_W = $clog2(COR_SETTLE + 1);

	logic [CNT_W-1:0] cnt;	// zero when idle

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cnt <= '0;
		end else if (i_last_data && (i_state == CORRELATION)) begin
			cnt <= CNT_W'(COR_SETTLE);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// done lands COR_SETTLE cycles after the last sample
	assign o_cor_done = (cnt == CNT_W'(1));

	a_done_in_cor: assert property (@(posedge clk) disable iff (!rst_b)
		o_cor_done |-> (i_state == CORRELATION));

endmodule

// ==== rtl/te_sequencer.sv ====
//--------------------------------------------------
// engine state machine and fifo control strobes
// strobes are registered and line up with their state
//--------------------------------------------------
module te_sequencer
	import te_pkg::*;
(
	input  logic      clk,
	input  logic      rst_b,
	input  logic      i_te_start,
	input  logic      i_fifo_ready,
	input  logic      i_enable_any,	// latched mask nonzero
	input  logic      i_find_done,
	input  logic      i_cor_done,
	input  logic      i_channels_left,
	output te_state_t o_state,
	output logic      o_fifo_read,
	output logic      o_fifo_rewind,
	output logic      o_fifo_skip,
	output logic      o_te_running,
	output logic      o_te_over
);

	te_state_t cur_state;
	te_state_t next_state;

	//--------------------------------------------------
	// state register and next state
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cur_state <= STAND_BY;
		end else begin
			cur_state <= next_state;
		end
	end

	always_comb begin
		case (cur_state)
			STAND_BY     : next_state = i_te_start ? IDLE : STAND_BY;
			IDLE         : next_state = i_fifo_ready ? START : IDLE;
			START        : next_state = i_enable_any ? FIND_CHANNEL : TE_FINISH;
			FIND_CHANNEL : next_state = i_find_done ? READ_FIFO : FIND_CHANNEL;
			READ_FIFO    : next_state = CORRELATION;
			CORRELATION  : next_state = i_cor_done ? DUMP_STATE : CORRELATION;
			DUMP_STATE   : next_state = COR_FINISH;
			COR_FINISH   : next_state = i_channels_left ? FIND_CHANNEL : TE_FINISH;
			TE_FINISH    : next_state = WAIT_CPU;
			WAIT_CPU     : next_state = i_te_start ? IDLE : WAIT_CPU;
			default      : next_state = STAND_BY;
		endcase
	end

	assign o_state      = cur_state;
	assign o_te_over    = (cur_state == TE_FINISH);	// one cycle per finished block
	assign o_te_running = (cur_state != STAND_BY) && (cur_state != WAIT_CPU);

	//--------------------------------------------------
	// fifo strobes
	//--------------------------------------------------
	// decoded from next state so each is high during its own state
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_fifo_read   <= 1'b0;
			o_fifo_rewind <= 1'b0;
			o_fifo_skip   <= 1'b0;
		end else begin
			o_fifo_read   <= (next_state == READ_FIFO);
			o_fifo_rewind <= (next_state == COR_FINISH) && i_channels_left;	// replay block
			o_fifo_skip   <= (next_state == TE_FINISH);
		end
	end

	// the fifo never sees a read together with a rewind or skip
	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_b)
		!(o_fifo_read && (o_fifo_rewind || o_fifo_skip)));

endmodule

// ==== rtl/te_pkg.sv ====
//--------------------------------------------------
// widths, state encoding and host register map
// NUM_CHANNELS must not exceed HOST_DW
//--------------------------------------------------
package te_pkg;

	localparam int NUM_CHANNELS = 32;	// logical channels
	localparam int NUM_SLOTS    = 4;	// physical slots per round
	localparam int SAMPLE_W     = 8;	// signed fifo sample
	localparam int HOST_DW      = 32;
	localparam int HOST_AW      = 6;

	// encoding has gaps for states not used in this engine
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		START        = 4'd1,
		FIND_CHANNEL = 4'd2,
		READ_FIFO    = 4'd5,
		CORRELATION  = 4'd6,
		DUMP_STATE   = 4'd8,
		COR_FINISH   = 4'd9,
		TE_FINISH    = 4'd10,
		WAIT_CPU     = 4'd11,
		STAND_BY     = 4'd12
	} te_state_t;

	// host register addresses
	localparam logic [HOST_AW-1:0] REG_CHANNEL_ENABLE = HOST_AW'(0);
	localparam logic [HOST_AW-1:0] REG_COH_DATA_READY = HOST_AW'(1);
	localparam logic [HOST_AW-1:0] REG_BLOCK_SUM      = HOST_AW'(2);
	localparam logic [HOST_AW-1:0] REG_CURR_STATE     = HOST_AW'(3);

	typedef struct packed {
		logic               reg_cs;	// register select
		logic               rd;
		logic               wr;
		logic [HOST_AW-1:0] addr;
		logic [HOST_DW-1:0] wdata;
	} host_bus_t;

	typedef struct packed {
		logic                ready;	// a block is waiting
		logic                last_data;
		logic                data_valid;
		logic [SAMPLE_W-1:0] data;
	} fifo_in_t;

	// one bit per logical channel served in the current round
	typedef struct packed {
		logic [NUM_CHANNELS-1:0] mask;
	} slot_map_t;

endpackage
